//--- riscv_isa_pkg.sv
////////////////////////////////////////
// RV32I encodings for the decoder subset
// Only OP, OP-IMM, LUI, AUIPC and JAL are known
// Field layout follows the base ISA, little end at bit 0
////////////////////////////////////////
`default_nettype none

package riscv_isa_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  // Major opcodes, bits 6:0
  localparam logic [6:0] OPC_OP    = 7'b0110011;
  localparam logic [6:0] OPC_OPIMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI   = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC = 7'b0010111;
  localparam logic [6:0] OPC_JAL   = 7'b1101111;

  localparam logic [2:0] FUNCT3_SHIFT_L = 3'b001; // SLLI
  localparam logic [2:0] FUNCT3_SHIFT_R = 3'b101; // SRLI and SRAI

  // One instruction word, read as R-type or as I-type
  typedef union packed {
    struct packed {
      logic [6:0]            funct7;
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      logic [6:0]            opcode;
    } r_view;
    struct packed {
      logic [11:0]           imm12;  // Bits 31:20
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      logic [6:0]            opcode;
    } i_view;
  } instr_u;

endpackage

`default_nettype wire

//--- decoder_ctrl_pkg.sv
////////////////////////////////////////
// Control encodings private to the decoder
// ALU select is {instr[30], funct3}, so ADD is zero
////////////////////////////////////////
`default_nettype none

package decoder_ctrl_pkg;

  localparam int ALU_SEL_W = 4;
  localparam logic [ALU_SEL_W-1:0] ALU_ADD = 4'b0000;

  // Instruction classes out of the opcode decode
  localparam int CLS_W = 3;
  localparam logic [CLS_W-1:0] CLS_NONE    = 3'd0; // No valid instruction
  localparam logic [CLS_W-1:0] CLS_OP      = 3'd1;
  localparam logic [CLS_W-1:0] CLS_OPIMM   = 3'd2;
  localparam logic [CLS_W-1:0] CLS_LUI     = 3'd3;
  localparam logic [CLS_W-1:0] CLS_AUIPC   = 3'd4;
  localparam logic [CLS_W-1:0] CLS_JAL     = 3'd5;
  localparam logic [CLS_W-1:0] CLS_ILLEGAL = 3'd6;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_STALL,  // One bubble for a RAW hazard
    SEQ_JAL     // Second JAL cycle
  } seq_state_e;

  typedef enum logic [1:0] {
    IMM_I,
    IMM_SHIFT,
    IMM_U,
    IMM_FOUR    // Link value pc+4
  } imm_sel_e;

endpackage

`default_nettype wire

//--- dec_ctrl_if.sv
////////////////////////////////////////
// Decoded control bundle, classify and
// sequencer into the output register
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface dec_ctrl_if;

  logic [decoder_ctrl_pkg::ALU_SEL_W-1:0]   alu_sel;
  logic [riscv_isa_pkg::REG_ADDR_W-1:0]     rf_addr_a;
  logic [riscv_isa_pkg::REG_ADDR_W-1:0]     rf_addr_b;
  logic [riscv_isa_pkg::REG_ADDR_W-1:0]     alu_dest;
  logic                                     is_imm;
  logic                                     use_pc;
  logic [riscv_isa_pkg::XLEN-1:0]           imm;
  logic                                     wb;      // Strobes from the sequencer
  logic                                     jmp;
  logic                                     illegal;

  modport cls  (output alu_sel, rf_addr_a, rf_addr_b, alu_dest, is_imm, use_pc, imm);
  modport seq  (output wb, jmp, illegal);
  modport regs (input alu_sel, rf_addr_a, rf_addr_b, alu_dest, is_imm, use_pc, imm,
                      wb, jmp, illegal);

endinterface

`default_nettype wire

//--- imm_gen.sv
////////////////////////////////////////
// Immediate forming for I, shift-I, U and J
// J immediate is always present on jimm_o
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
  input  riscv_isa_pkg::instr_u             instr_i,
  input  decoder_ctrl_pkg::imm_sel_e        sel_i,
  output logic [riscv_isa_pkg::XLEN-1:0]    imm_o,
  output logic [riscv_isa_pkg::XLEN-1:0]    jimm_o
);

  logic [11:0] imm12;
  logic [19:0] upper;

  assign imm12 = instr_i.i_view.imm12;
  assign upper = {instr_i.i_view.imm12, instr_i.i_view.rs1, instr_i.i_view.funct3};

  // imm[20|10:1|11|19:12] sits in bits 31:12
  assign jimm_o = {{12{imm12[11]}}, upper[7:0], imm12[0], imm12[10:1], 1'b0};

  always_comb begin
    case (sel_i)
      decoder_ctrl_pkg::IMM_I:     imm_o = {{20{imm12[11]}}, imm12};
      decoder_ctrl_pkg::IMM_SHIFT: imm_o = {27'b0, imm12[4:0]}; // shamt, never signed
      decoder_ctrl_pkg::IMM_U:     imm_o = {upper, 12'b0};
      decoder_ctrl_pkg::IMM_FOUR:  imm_o = 32'd4;
      default:                     imm_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- instr_classify.sv
////////////////////////////////////////
// Opcode decode into class and ALU controls
// Unknown opcodes come out as CLS_ILLEGAL
// Immediate is zero unless is_imm is set
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module instr_classify (
  input  riscv_isa_pkg::instr_u                   instr_i,
  dec_ctrl_if.cls                                 ctrl,
  output logic [decoder_ctrl_pkg::CLS_W-1:0]      cls_o,
  output logic [riscv_isa_pkg::REG_ADDR_W-1:0]    rs1_o,
  output logic [riscv_isa_pkg::REG_ADDR_W-1:0]    rs2_o,
  output logic [riscv_isa_pkg::XLEN-1:0]          jimm_o
);

  decoder_ctrl_pkg::imm_sel_e          imm_sel;
  logic [riscv_isa_pkg::XLEN-1:0]      imm_raw;
  logic                                shift_op;

  assign rs1_o    = instr_i.r_view.rs1;
  assign rs2_o    = instr_i.r_view.rs2;
  assign shift_op = (instr_i.i_view.funct3 == riscv_isa_pkg::FUNCT3_SHIFT_L) ||
                    (instr_i.i_view.funct3 == riscv_isa_pkg::FUNCT3_SHIFT_R);

  imm_gen imm_gen0 (
    .instr_i (instr_i),
    .sel_i   (imm_sel),
    .imm_o   (imm_raw),
    .jimm_o  (jimm_o)
  );

  always_comb begin
    case (instr_i.r_view.opcode)
      riscv_isa_pkg::OPC_OP:    cls_o = decoder_ctrl_pkg::CLS_OP;
      riscv_isa_pkg::OPC_OPIMM: cls_o = decoder_ctrl_pkg::CLS_OPIMM;
      riscv_isa_pkg::OPC_LUI:   cls_o = decoder_ctrl_pkg::CLS_LUI;
      riscv_isa_pkg::OPC_AUIPC: cls_o = decoder_ctrl_pkg::CLS_AUIPC;
      riscv_isa_pkg::OPC_JAL:   cls_o = decoder_ctrl_pkg::CLS_JAL;
      default:                  cls_o = decoder_ctrl_pkg::CLS_ILLEGAL;
    endcase
  end

  ////////////////////////////////////////
  // Per-class controls
  always_comb begin
    ctrl.alu_sel   = decoder_ctrl_pkg::ALU_ADD;
    ctrl.rf_addr_a = '0;
    ctrl.rf_addr_b = '0;
    ctrl.alu_dest  = instr_i.r_view.rd;
    ctrl.is_imm    = 1'b1;
    ctrl.use_pc    = 1'b0;
    imm_sel        = decoder_ctrl_pkg::IMM_I;
    case (cls_o)
      decoder_ctrl_pkg::CLS_OP: begin
        ctrl.alu_sel   = {instr_i.r_view.funct7[5], instr_i.r_view.funct3};
        ctrl.rf_addr_a = instr_i.r_view.rs1;
        ctrl.rf_addr_b = instr_i.r_view.rs2;
        ctrl.is_imm    = 1'b0;
      end
      decoder_ctrl_pkg::CLS_OPIMM: begin
        ctrl.rf_addr_a = instr_i.i_view.rs1;
        if (shift_op) begin
          ctrl.alu_sel = {instr_i.i_view.imm12[10], instr_i.i_view.funct3}; // Bit 30 picks SRA
          imm_sel      = decoder_ctrl_pkg::IMM_SHIFT;
        end else begin
          ctrl.alu_sel = {1'b0, instr_i.i_view.funct3};
        end
      end
      decoder_ctrl_pkg::CLS_LUI: imm_sel = decoder_ctrl_pkg::IMM_U; // x0 + imm
      decoder_ctrl_pkg::CLS_AUIPC: begin
        imm_sel     = decoder_ctrl_pkg::IMM_U;
        ctrl.use_pc = 1'b1;
      end
      decoder_ctrl_pkg::CLS_JAL: begin
        imm_sel     = decoder_ctrl_pkg::IMM_FOUR;
        ctrl.use_pc = 1'b1;
      end
      default: begin
        ctrl.alu_dest = '0;
        ctrl.is_imm   = 1'b0;
      end
    endcase
  end

  assign ctrl.imm = ctrl.is_imm ? imm_raw : '0;

endmodule

`default_nettype wire

//--- decode_seq.sv
////////////////////////////////////////
// Decode sequencer
// One bubble on a RAW hit against the last retired rd
// JAL takes two cycles, ready_o is combinational
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module decode_seq (
  input  logic                                  clk_i,
  input  logic                                  rstn_i,
  input  logic                                  valid_i,
  input  logic [decoder_ctrl_pkg::CLS_W-1:0]    cls_i,
  input  logic [riscv_isa_pkg::REG_ADDR_W-1:0]  rs1_i,
  input  logic [riscv_isa_pkg::REG_ADDR_W-1:0]  rs2_i,
  input  logic [riscv_isa_pkg::REG_ADDR_W-1:0]  rd_i,
  dec_ctrl_if.seq                               ctrl,
  output logic                                  ready_o
);

  decoder_ctrl_pkg::seq_state_e            state_q;
  decoder_ctrl_pkg::seq_state_e            state_d;
  logic [riscv_isa_pkg::REG_ADDR_W-1:0]    prev_dest_q;
  logic [decoder_ctrl_pkg::CLS_W-1:0]      cls;
  logic                                    rs1_hit;
  logic                                    rs2_hit;
  logic                                    hazard;
  logic                                    writes_rd;
  logic                                    retire;

  assign cls     = valid_i ? cls_i : decoder_ctrl_pkg::CLS_NONE;
  assign rs1_hit = (rs1_i != '0) && (rs1_i == prev_dest_q);
  assign rs2_hit = (rs2_i != '0) && (rs2_i == prev_dest_q);

  // Only checked on the first cycle, OP-IMM has no rs2
  assign hazard = (state_q == decoder_ctrl_pkg::SEQ_IDLE) &&
                  (((cls == decoder_ctrl_pkg::CLS_OP) && (rs1_hit || rs2_hit)) ||
                   ((cls == decoder_ctrl_pkg::CLS_OPIMM) && rs1_hit));

  assign writes_rd = cls inside {decoder_ctrl_pkg::CLS_OP, decoder_ctrl_pkg::CLS_OPIMM,
                                 decoder_ctrl_pkg::CLS_LUI, decoder_ctrl_pkg::CLS_AUIPC,
                                 decoder_ctrl_pkg::CLS_JAL};
  assign retire    = valid_i && ready_o;

  ////////////////////////////////////////
  // Next state and strobes
  always_comb begin
    state_d      = decoder_ctrl_pkg::SEQ_IDLE;
    ready_o      = 1'b1;
    ctrl.wb      = 1'b0;
    ctrl.jmp     = 1'b0;
    ctrl.illegal = 1'b0;
    if (state_q == decoder_ctrl_pkg::SEQ_JAL) begin
      // Link already written, just release fetch
    end else if (hazard) begin
      state_d = decoder_ctrl_pkg::SEQ_STALL;
      ready_o = 1'b0;
    end else if (cls == decoder_ctrl_pkg::CLS_JAL) begin
      state_d  = decoder_ctrl_pkg::SEQ_JAL;
      ready_o  = 1'b0;
      ctrl.wb  = 1'b1;  // rd <= pc+4
      ctrl.jmp = 1'b1;
    end else if (cls == decoder_ctrl_pkg::CLS_ILLEGAL) begin
      ctrl.illegal = 1'b1;
    end else begin
      ctrl.wb = writes_rd;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      state_q     <= decoder_ctrl_pkg::SEQ_IDLE;
      prev_dest_q <= '0;
    end else begin
      state_q <= state_d;
      if (retire && (cls == decoder_ctrl_pkg::CLS_ILLEGAL)) begin
        prev_dest_q <= '0;   // Forget hazard memory
      end else if (retire && writes_rd) begin
        prev_dest_q <= rd_i;
      end
    end
  end

endmodule

`default_nettype wire

//--- decode_out_reg.sv
////////////////////////////////////////
// Output register of the decoder, one stage
// jmp_addr_o is zero outside a jump cycle
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module decode_out_reg (
  input  logic                                  clk_i,
  input  logic                                  rstn_i,
  dec_ctrl_if.regs                              ctrl,
  input  logic [riscv_isa_pkg::XLEN-1:0]        instr_addr_i,
  input  logic [riscv_isa_pkg::XLEN-1:0]        jimm_i,
  output logic [decoder_ctrl_pkg::ALU_SEL_W-1:0] alu_sel_o,
  output logic [riscv_isa_pkg::REG_ADDR_W-1:0]  rf_addr_a_o,
  output logic [riscv_isa_pkg::REG_ADDR_W-1:0]  rf_addr_b_o,
  output logic [riscv_isa_pkg::REG_ADDR_W-1:0]  alu_dest_o,
  output logic                                  is_imm_o,
  output logic                                  use_pc_o,
  output logic [riscv_isa_pkg::XLEN-1:0]        imm_o,
  output logic                                  wb_o,
  output logic                                  illegal_o,
  output logic                                  jmp_o,
  output logic [riscv_isa_pkg::XLEN-1:0]        jmp_addr_o,
  output logic [riscv_isa_pkg::XLEN-1:0]        instr_addr_o
);

  logic [riscv_isa_pkg::XLEN-1:0] jmp_addr_d;

  assign jmp_addr_d = ctrl.jmp ? (instr_addr_i + jimm_i) : '0; // Dedicated JAL adder

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      alu_sel_o    <= '0;
      rf_addr_a_o  <= '0;
      rf_addr_b_o  <= '0;
      alu_dest_o   <= '0;
      is_imm_o     <= 1'b0;
      use_pc_o     <= 1'b0;
      imm_o        <= '0;
      wb_o         <= 1'b0;
      illegal_o    <= 1'b0;
      jmp_o        <= 1'b0;
      jmp_addr_o   <= '0;
      instr_addr_o <= '0;
    end else begin
      alu_sel_o    <= ctrl.alu_sel;
      rf_addr_a_o  <= ctrl.rf_addr_a;
      rf_addr_b_o  <= ctrl.rf_addr_b;
      alu_dest_o   <= ctrl.alu_dest;
      is_imm_o     <= ctrl.is_imm;
      use_pc_o     <= ctrl.use_pc;
      imm_o        <= ctrl.imm;
      wb_o         <= ctrl.wb;
      illegal_o    <= ctrl.illegal;
      jmp_o        <= ctrl.jmp;
      jmp_addr_o   <= jmp_addr_d;
      instr_addr_o <= instr_addr_i;  // Follows the input every cycle
    end
  end

endmodule

`default_nettype wire

//--- rv_decoder.sv
////////////////////////////////////////
// RV32I subset decoder, valid/ready on the fetch side
// Hold instr_i until instr_valid_i and ready_o meet on an edge
// Outputs are registered, no downstream back-pressure
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
  input  logic                                   clk_i,
  input  logic                                   rstn_i,
  input  logic [riscv_isa_pkg::XLEN-1:0]         instr_i,
  input  logic [riscv_isa_pkg::XLEN-1:0]         instr_addr_i,
  input  logic                                   instr_valid_i,
  output logic                                   ready_o,
  output logic                                   illegal_instr_o,
  output logic [decoder_ctrl_pkg::ALU_SEL_W-1:0] alu_sel_o,
  output logic [riscv_isa_pkg::REG_ADDR_W-1:0]   rf_addr_a_o,
  output logic [riscv_isa_pkg::REG_ADDR_W-1:0]   rf_addr_b_o,
  output logic [riscv_isa_pkg::REG_ADDR_W-1:0]   alu_dest_addr_o,
  output logic                                   alu_wb_o,
  output logic                                   is_imm_o,
  output logic                                   use_pc_o,
  output logic [riscv_isa_pkg::XLEN-1:0]         imm_ext_o,
  output logic [riscv_isa_pkg::XLEN-1:0]         instr_addr_o,
  output logic                                   jmp_o,
  output logic [riscv_isa_pkg::XLEN-1:0]         jmp_addr_o
);

  riscv_isa_pkg::instr_u                  instr;
  logic [decoder_ctrl_pkg::CLS_W-1:0]     cls;
  logic [riscv_isa_pkg::REG_ADDR_W-1:0]   rs1;
  logic [riscv_isa_pkg::REG_ADDR_W-1:0]   rs2;
  logic [riscv_isa_pkg::XLEN-1:0]         jimm;

  assign instr = instr_i;

  dec_ctrl_if ctrl_if ();

  instr_classify classify0 (
    .instr_i (instr),
    .ctrl    (ctrl_if.cls),
    .cls_o   (cls),
    .rs1_o   (rs1),
    .rs2_o   (rs2),
    .jimm_o  (jimm)
  );

  decode_seq seq0 (
    .clk_i   (clk_i),
    .rstn_i  (rstn_i),
    .valid_i (instr_valid_i),
    .cls_i   (cls),
    .rs1_i   (rs1),
    .rs2_i   (rs2),
    .rd_i    (ctrl_if.alu_dest),  // Zero for illegal opcodes
    .ctrl    (ctrl_if.seq),
    .ready_o (ready_o)
  );

  decode_out_reg out_reg0 (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .ctrl         (ctrl_if.regs),
    .instr_addr_i (instr_addr_i),
    .jimm_i       (jimm),
    .alu_sel_o    (alu_sel_o),
    .rf_addr_a_o  (rf_addr_a_o),
    .rf_addr_b_o  (rf_addr_b_o),
    .alu_dest_o   (alu_dest_addr_o),
    .is_imm_o     (is_imm_o),
    .use_pc_o     (use_pc_o),
    .imm_o        (imm_ext_o),
    .wb_o         (alu_wb_o),
    .illegal_o    (illegal_instr_o),
    .jmp_o        (jmp_o),
    .jmp_addr_o   (jmp_addr_o),
    .instr_addr_o (instr_addr_o)
  );

endmodule

`default_nettype wire

//--- tb_rv_decoder.sv
////////////////////////////////////////
// Testbench for the RV32I subset decoder
// Table entries run in order, so hazard memory carries over
// Addresses are random and word aligned
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_rv_decoder;

  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] ofs;      // J offset, zero for the rest
    logic [1:0]  stall;    // Cycles with ready_o low
    logic [3:0]  alu_sel;
    logic [4:0]  a;
    logic [4:0]  b;
    logic [4:0]  dest;
    logic        is_imm;
    logic        use_pc;
    logic [31:0] imm;
    logic        wb;
    logic        jmp;
    logic        illegal;
  } entry_t;

  logic        clk_i = 1'b0;
  logic        rstn_i;
  logic [31:0] instr_i;
  logic [31:0] instr_addr_i;
  logic        instr_valid_i;
  logic        ready_o;
  logic        illegal_instr_o;
  logic [3:0]  alu_sel_o;
  logic [4:0]  rf_addr_a_o;
  logic [4:0]  rf_addr_b_o;
  logic [4:0]  alu_dest_addr_o;
  logic        alu_wb_o;
  logic        is_imm_o;
  logic        use_pc_o;
  logic [31:0] imm_ext_o;
  logic [31:0] instr_addr_o;
  logic        jmp_o;
  logic [31:0] jmp_addr_o;

  entry_t      stim [16];
  logic [31:0] addr [16];
  int          n_entries = 0;
  int          cycles = 0;
  int          cycle_limit = 1000;
  int          fail_count = 0;

  rv_decoder dut0 (
    .clk_i (clk_i), .rstn_i (rstn_i), .instr_i (instr_i), .instr_addr_i (instr_addr_i),
    .instr_valid_i (instr_valid_i), .ready_o (ready_o), .illegal_instr_o (illegal_instr_o),
    .alu_sel_o (alu_sel_o), .rf_addr_a_o (rf_addr_a_o), .rf_addr_b_o (rf_addr_b_o),
    .alu_dest_addr_o (alu_dest_addr_o), .alu_wb_o (alu_wb_o), .is_imm_o (is_imm_o),
    .use_pc_o (use_pc_o), .imm_ext_o (imm_ext_o), .instr_addr_o (instr_addr_o),
    .jmp_o (jmp_o), .jmp_addr_o (jmp_addr_o)
  );

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout: the run went past %0d cycles without finishing", cycle_limit);
      $display("Checks failed");
      $fatal(1);
    end
  end

  ////////////////////////////////////////
  // Instruction encoders, base ISA layout
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm12, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {imm12, rs1, f3, rd, 7'b0010011};  // OP-IMM
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm20, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm20, rd, opc};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] ofs, input logic [4:0] rd);
    return {ofs[20], ofs[10:1], ofs[11], ofs[19:12], rd, 7'b1101111};
  endfunction

  ////////////////////////////////////////
  // Table and checks
  task automatic add_entry(input logic [31:0] instr, input logic [31:0] ofs,
                           input logic [1:0] stall, input logic [3:0] alu_sel,
                           input logic [4:0] a, input logic [4:0] b, input logic [4:0] dest,
                           input logic is_imm, input logic use_pc, input logic [31:0] imm,
                           input logic wb, input logic jmp, input logic illegal);
    entry_t e;
    e.instr = instr;
    e.ofs = ofs;
    e.stall = stall;
    e.alu_sel = alu_sel;
    e.a = a;
    e.b = b;
    e.dest = dest;
    e.is_imm = is_imm;
    e.use_pc = use_pc;
    e.imm = imm;
    e.wb = wb;
    e.jmp = jmp;
    e.illegal = illegal;
    stim[n_entries] = e;
    n_entries++;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      fail_count++;
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("Checks failed");
      $fatal(1);
    end
  endtask

  task automatic check_strobes_low();
    check_value("alu_wb_o", alu_wb_o, 0);
    check_value("jmp_o", jmp_o, 0);
    check_value("illegal_instr_o", illegal_instr_o, 0);
    check_value("jmp_addr_o", jmp_addr_o, 0);
  endtask

  task automatic check_fields(input entry_t e, input logic [31:0] a);
    check_value("alu_sel_o", alu_sel_o, e.alu_sel);
    check_value("rf_addr_a_o", rf_addr_a_o, e.a);
    check_value("rf_addr_b_o", rf_addr_b_o, e.b);
    check_value("alu_dest_addr_o", alu_dest_addr_o, e.dest);
    check_value("is_imm_o", is_imm_o, e.is_imm);
    check_value("use_pc_o", use_pc_o, e.use_pc);
    check_value("imm_ext_o", imm_ext_o, e.imm);
    check_value("alu_wb_o", alu_wb_o, e.wb);
    check_value("jmp_o", jmp_o, e.jmp);
    check_value("jmp_addr_o", jmp_addr_o, e.jmp ? a + e.ofs : 32'h0);
    check_value("illegal_instr_o", illegal_instr_o, e.illegal);
    check_value("instr_addr_o", instr_addr_o, a);
  endtask

  initial begin
    int unsigned seed;
    int unsigned rnd;
    int          total;
    int          waits;
    entry_t      e;
    seed = 32'h27b1a930;
    rnd = $urandom(seed);
    rstn_i = 1'b0;
    instr_i = 32'h0;
    instr_addr_i = 32'h0;
    instr_valid_i = 1'b0;

    add_entry(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 0, 0,         // ADD x3,x1,x2
              4'h0, 5'd1, 5'd2, 5'd3, 0, 0, 32'h0, 1, 0, 0);
    add_entry(enc_r(7'h20, 5'd4, 5'd3, 3'b000, 5'd5), 0, 1,         // SUB reads x3
              4'h8, 5'd3, 5'd4, 5'd5, 0, 0, 32'h0, 1, 0, 0);
    add_entry(enc_i(12'h40D, 5'd7, 3'b101, 5'd6), 0, 0,             // SRAI x6,x7,13
              4'hD, 5'd7, 5'd0, 5'd6, 1, 0, 32'd13, 1, 0, 0);
    add_entry(enc_i(12'hFF0, 5'd6, 3'b111, 5'd8), 0, 1,             // ANDI reads x6
              4'h7, 5'd6, 5'd0, 5'd8, 1, 0, 32'hFFFF_FFF0, 1, 0, 0);
    add_entry(enc_i(12'h001, 5'd0, 3'b000, 5'd0), 0, 0,             // ADDI x0,x0,1
              4'h0, 5'd0, 5'd0, 5'd0, 1, 0, 32'd1, 1, 0, 0);
    // Last rd is x0 here, x0 sources must not stall
    add_entry(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd10), 0, 0,
              4'h0, 5'd0, 5'd0, 5'd10, 0, 0, 32'h0, 1, 0, 0);
    add_entry(enc_u(20'h12345, 5'd11, 7'b0110111), 0, 0,            // LUI
              4'h0, 5'd0, 5'd0, 5'd11, 1, 0, 32'h1234_5000, 1, 0, 0);
    add_entry(enc_u(20'hFEDCB, 5'd12, 7'b0010111), 0, 0,            // AUIPC
              4'h0, 5'd0, 5'd0, 5'd12, 1, 1, 32'hFEDC_B000, 1, 0, 0);
    add_entry(enc_j(21'h181A2C, 5'd1), 32'hFFF8_1A2C, 1,            // JAL x1, backward
              4'h0, 5'd0, 5'd0, 5'd1, 1, 1, 32'd4, 1, 1, 0);
    add_entry(32'h0000_2083, 0, 0,                                  // LW is not decoded
              4'h0, 5'd0, 5'd0, 5'd0, 0, 0, 32'h0, 0, 0, 1);
    // Would hit x1 from the JAL without the illegal in between
    add_entry(enc_r(7'h00, 5'd1, 5'd1, 3'b000, 5'd2), 0, 0,
              4'h0, 5'd1, 5'd1, 5'd2, 0, 0, 32'h0, 1, 0, 0);
    // Dependency through rs2 only
    add_entry(enc_r(7'h00, 5'd2, 5'd5, 3'b110, 5'd9), 0, 1,         // OR reads x2
              4'h6, 5'd5, 5'd2, 5'd9, 0, 0, 32'h0, 1, 0, 0);

    total = 4;
    for (int i = 0; i < n_entries; i++) begin
      addr[i] = rnd & 32'hFFFF_FFFC;
      rnd = $urandom;
      total += stim[i].stall + 2;
    end
    cycle_limit = 3 * total + 4;

    repeat (4) @(posedge clk_i);
    rstn_i <= 1'b1;
    @(negedge clk_i);
    check_fields('0, 32'h0);  // All outputs at reset value
    check_value("ready_o", ready_o, 1);
    repeat (3) begin
      @(posedge clk_i);
      @(negedge clk_i);
      check_strobes_low();
      check_value("ready_o", ready_o, 1);
    end
    @(posedge clk_i);

    for (int i = 0; i < n_entries; i++) begin
      e = stim[i];
      instr_i <= e.instr;
      instr_addr_i <= addr[i];
      instr_valid_i <= 1'b1;
      waits = 0;
      @(negedge clk_i);
      check_strobes_low();  // Idle cycle before this entry
      while (!ready_o) begin
        @(posedge clk_i);
        @(negedge clk_i);
        waits++;
        assert (waits <= 3) else begin
          $display("ready_o stayed low for more than 3 cycles on entry %0d", i);
          $display("Checks failed");
          $fatal(1);
        end
        if (e.jmp) begin
          check_fields(e, addr[i]);  // JAL strobes on its first edge
        end else begin
          check_strobes_low();       // Hazard bubble
          check_value("instr_addr_o", instr_addr_o, addr[i]);
        end
      end
      @(posedge clk_i);
      instr_valid_i <= 1'b0;
      @(negedge clk_i);
      check_value("stall cycles", waits, e.stall);
      if (e.jmp) begin
        check_strobes_low();
        check_value("instr_addr_o", instr_addr_o, addr[i]);
      end else begin
        check_fields(e, addr[i]);
      end
      @(posedge clk_i);
    end

    if (fail_count == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("Checks failed");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

//--- rv_decoder.f
riscv_isa_pkg.sv
decoder_ctrl_pkg.sv
dec_ctrl_if.sv
imm_gen.sv
instr_classify.sv
decode_seq.sv
decode_out_reg.sv
rv_decoder.sv
tb_rv_decoder.sv

//--- Bender.yml
package:
  name: rv_decoder

sources:
  - riscv_isa_pkg.sv
  - decoder_ctrl_pkg.sv
  - dec_ctrl_if.sv
  - imm_gen.sv
  - instr_classify.sv
  - decode_seq.sv
  - decode_out_reg.sv
  - rv_decoder.sv
  - target: simulation
    files:
      - tb_rv_decoder.sv
